/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module tbEndpoint0 -Mdir obj_dir
	out="$$(./obj_dir/VtbEndpoint0)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* descRom.sv */
`timescale 1ns/1ps
`default_nettype none

module descRom (
    input  logic [ep0Pkg::RomIdxWidth-1:0] idx_i,
    output logic [7:0] data_o
);
    import ep0Pkg::*;

    // ====================
    // Lookup
    // ====================

    // Pure table lookup, no clock
    always_comb begin
        data_o = 8'h00;
        // Index space is wider than the table
        if (int'(idx_i) < $size(DescRomBytes)) begin
            data_o = DescRomBytes[idx_i];
        end
    end

endmodule

`default_nettype wire

/* deviceStateTracker.sv */
`timescale 1ns/1ps
`default_nettype none

module deviceStateTracker (
    input  logic clk48_i,
    input  logic rstN_i,
    input  logic usbReset_i,
    input  logic addrCommit_i,
    input  logic confCommit_i,
    ep0ReqIf.user req,
    output ep0Pkg::DeviceState devState_o,
    output logic [ep0Pkg::DevAddrWidth-1:0] deviceAddr_o,
    output logic [ep0Pkg::DevConfWidth-1:0] deviceConf_o,
    output logic ackUsbReset_o
);
    import ep0Pkg::*;

    // Bus reset is acknowledged for as long as we sit in DEFAULT
    assign ackUsbReset_o = devState_o == DEV_DEFAULT;

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            devState_o <= DEV_NOT_RESET;
            deviceAddr_o <= '0;
            deviceConf_o <= '0;
        end else if (usbReset_i) begin
            // Back to default address, unconfigured
            devState_o <= DEV_DEFAULT;
            deviceAddr_o <= '0;
            deviceConf_o <= '0;
        end else if (confCommit_i) begin
            deviceConf_o <= req.wValue[DevConfWidth-1:0];
            // Configuration zero drops back to addressed
            if (req.wValue[DevConfWidth-1:0] == '0) begin
                devState_o <= DEV_ADDRESSED;
            end else begin
                devState_o <= DEV_CONFIGURED;
            end
        end else if (addrCommit_i) begin
            deviceAddr_o <= req.wValue[DevAddrWidth-1:0];
            if (req.wValue[DevAddrWidth-1:0] == '0) begin
                devState_o <= DEV_DEFAULT;
            end else begin
                devState_o <= DEV_ADDRESSED;
            end
        end
    end

endmodule

`default_nettype wire

/* ep0ByteCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module ep0ByteCounter (
    input  logic clk48_i,
    input  logic rstN_i,
    input  logic loadCount_i,
    input  logic [ep0Pkg::RomIdxWidth-1:0] romStart_i,
    input  logic popByte_i,
    input  logic commitTrans_i,
    input  logic rollbackTrans_i,
    ep0ReqIf.user req,
    output logic [ep0Pkg::RomIdxWidth-1:0] romIdx_o,
    output logic [15:0] bytesLeft_o
);
    import ep0Pkg::*;

    // Values at the end of the last good IN transaction
    logic [RomIdxWidth-1:0] romIdxCommit;
    logic [15:0] bytesLeftCommit;

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            romIdx_o <= '0;
            romIdxCommit <= '0;
            bytesLeft_o <= '0;
            bytesLeftCommit <= '0;
        end else if (loadCount_i) begin
            // New request, both copies start equal
            romIdx_o <= romStart_i;
            romIdxCommit <= romStart_i;
            bytesLeft_o <= req.wLength;
            bytesLeftCommit <= req.wLength;
        end else if (popByte_i) begin
            romIdx_o <= romIdx_o + 1'b1;
            bytesLeft_o <= bytesLeft_o - 1'b1;
        end else if (commitTrans_i) begin
            // Host got the packet
            romIdxCommit <= romIdx_o;
            bytesLeftCommit <= bytesLeft_o;
        end else if (rollbackTrans_i) begin
            // Packet lost, the retry resends the same bytes
            romIdx_o <= romIdxCommit;
            bytesLeft_o <= bytesLeftCommit;
        end
    end

endmodule

`default_nettype wire

/* ep0Pkg.sv */
`default_nettype none

package ep0Pkg;

    // ====================
    // Widths
    // ====================

    // USB device address is seven bits wide
    localparam int DevAddrWidth = 7;
    localparam int DevConfWidth = 8;
    // Setup payload size, PID byte not counted
    localparam int SetupBytes = 8;
    localparam int RomIdxWidth = 5;

    // ====================
    // Descriptor ROM
    // ====================

    // Configuration descriptor follows the device descriptor
    localparam int ConfDescStart = 18;

    localparam logic [7:0] DescRomBytes [27] = '{
        // Device descriptor, bcdUSB 2.00, EP0 max packet 8
        8'h12, 8'h01, 8'h00, 8'h02, 8'h00, 8'h00, 8'h00, 8'h08,
        // Vendor and product IDs, bcdDevice 1.00
        8'hCD, 8'hAB, 8'h01, 8'h00, 8'h00, 8'h01,
        // No string indices, one configuration
        8'h00, 8'h00, 8'h00, 8'h01,
        // Configuration descriptor, total length 9, no interfaces
        8'h09, 8'h02, 8'h09, 8'h00, 8'h00, 8'h01, 8'h00, 8'h80,
        // Max power 100 mA
        8'h32
    };

    // ====================
    // Codes
    // ====================

    // Token PID bits 3:2
    typedef enum logic [1:0] {
        TOKEN_OUT   = 2'b00,
        TOKEN_IN    = 2'b10,
        TOKEN_SETUP = 2'b11
    } TokenId;

    // Standard bRequest values
    typedef enum logic [7:0] {
        GET_STATUS        = 8'd0,
        CLEAR_FEATURE     = 8'd1,
        SET_FEATURE       = 8'd3,
        SET_ADDRESS       = 8'd5,
        GET_DESCRIPTOR    = 8'd6,
        SET_DESCRIPTOR    = 8'd7,
        GET_CONFIGURATION = 8'd8,
        SET_CONFIGURATION = 8'd9,
        GET_INTERFACE     = 8'd10,
        SET_INTERFACE     = 8'd11,
        SYNCH_FRAME       = 8'd12
    } RequestCode;

    // Descriptor type, high byte of wValue
    typedef enum logic [7:0] {
        DESC_DEVICE        = 8'd1,
        DESC_CONFIGURATION = 8'd2
    } DescType;

    typedef enum logic [1:0] {
        DEV_NOT_RESET,
        DEV_DEFAULT,
        DEV_ADDRESSED,
        DEV_CONFIGURED
    } DeviceState;

    typedef enum logic [1:0] {
        NEW_REQUEST,
        SEND_DESC,
        SEND_VAL,
        IDLE
    } Ep0State;

    // Handshake PID bits 3:2
    typedef enum logic [1:0] {
        RES_ACK   = 2'b00,
        RES_STALL = 2'b11
    } RespPid;

endpackage

`default_nettype wire

/* ep0ReqIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface ep0ReqIf;

    // Fields of the captured setup packet
    logic [7:0]  bRequest;
    logic [15:0] wValue;
    logic [15:0] wIndex;
    logic [15:0] wLength;
    // Direction bit of bmRequestType
    logic        devToHost;

    // Setup capture owns all fields
    modport capture (
        output bRequest, wValue, wIndex, wLength, devToHost
    );

    modport user (
        input bRequest, wValue, wIndex, wLength, devToHost
    );

endinterface

`default_nettype wire

/* ep0RequestFsm.sv */
`timescale 1ns/1ps
`default_nettype none

module ep0RequestFsm (
    input  logic clk48_i,
    input  logic rstN_i,
    input  logic transStart_i,
    input  ep0Pkg::TokenId tokenId_i,
    input  logic fillDone_i,
    input  logic fillSuccess_i,
    input  logic popData_i,
    input  logic popDone_i,
    input  logic popSuccess_i,
    input  logic [15:0] bytesLeft_i,
    input  ep0Pkg::DeviceState devState_i,
    ep0ReqIf.user req,
    output ep0Pkg::Ep0State ep0State_o,
    output logic dataAvailable_o,
    output logic lastByte_o,
    output logic addrCommit_o,
    output logic confCommit_o,
    output logic loadCount_o,
    output logic [ep0Pkg::RomIdxWidth-1:0] romStart_o,
    output logic popByte_o,
    output logic commitTrans_o,
    output logic rollbackTrans_o,
    output logic respHandshakePid_o,
    output logic [1:0] respPacketId_o
);
    import ep0Pkg::*;

    Ep0State nextState;
    logic requestError, nextError;
    // High means DATA1 on the next IN packet
    logic dataToggle, nextToggle;
    // Valid SET_ADDRESS seen, waiting for the status stage
    logic pendingAddr, nextPendingAddr;
    logic confStateOk;

    assign confStateOk = devState_i == DEV_ADDRESSED || devState_i == DEV_CONFIGURED;

    // ====================
    // Outputs to the PE
    // ====================

    assign dataAvailable_o = bytesLeft_i != '0
        && (ep0State_o == SEND_DESC || ep0State_o == SEND_VAL);
    assign lastByte_o = bytesLeft_i == 16'd1;

    // Host to device requests and errors only get a handshake
    assign respHandshakePid_o = !req.devToHost || requestError;
    assign respPacketId_o = tokenId_i == TOKEN_IN ? {dataToggle, 1'b0}
        : (requestError ? RES_STALL : RES_ACK);

    // ====================
    // Next state
    // ====================

    always_comb begin
        nextState = ep0State_o;
        nextError = requestError;
        nextToggle = dataToggle;
        nextPendingAddr = pendingAddr;
        addrCommit_o = 1'b0;
        confCommit_o = 1'b0;
        loadCount_o = 1'b0;
        romStart_o = '0;
        popByte_o = 1'b0;
        commitTrans_o = 1'b0;
        rollbackTrans_o = 1'b0;

        if (transStart_i) begin
            nextError = 1'b0;
            nextPendingAddr = 1'b0;
            if (tokenId_i == TOKEN_SETUP) begin
                nextState = NEW_REQUEST;
            end else if (tokenId_i == TOKEN_IN && pendingAddr) begin
                // Status stage of SET_ADDRESS, new address applies now
                addrCommit_o = 1'b1;
            end
        end else if (ep0State_o == NEW_REQUEST) begin
            if (fillDone_i) begin
                nextState = IDLE;
                if (fillSuccess_i) begin
                    // Data and status stages start with DATA1
                    nextToggle = 1'b1;
                    loadCount_o = 1'b1;
                    case (req.bRequest)
                        SET_ADDRESS: begin
                            if (req.wValue < 16'd128 && devState_i != DEV_CONFIGURED) begin
                                nextPendingAddr = 1'b1;
                            end else begin
                                nextError = 1'b1;
                            end
                        end
                        SET_CONFIGURATION: begin
                            // Only configuration 1 exists
                            if (confStateOk && req.wValue <= 16'd1) begin
                                confCommit_o = 1'b1;
                            end else begin
                                nextError = 1'b1;
                            end
                        end
                        GET_CONFIGURATION: begin
                            if (confStateOk) begin
                                nextState = SEND_VAL;
                            end else begin
                                nextError = 1'b1;
                            end
                        end
                        GET_DESCRIPTOR: begin
                            case (req.wValue[15:8])
                                DESC_DEVICE: begin
                                    nextState = SEND_DESC;
                                end
                                DESC_CONFIGURATION: begin
                                    if (req.wValue[7:0] == 8'd0) begin
                                        nextState = SEND_DESC;
                                        romStart_o = RomIdxWidth'(ConfDescStart);
                                    end else begin
                                        nextError = 1'b1;
                                    end
                                end
                                default: begin
                                    nextError = 1'b1;
                                end
                            endcase
                        end
                        // Everything else stalls
                        default: begin
                            nextError = 1'b1;
                        end
                    endcase
                end
            end
        end else if (popData_i && dataAvailable_o) begin
            popByte_o = 1'b1;
        end else if (popDone_i) begin
            if (popSuccess_i) begin
                commitTrans_o = 1'b1;
                nextToggle = !dataToggle;
            end else begin
                rollbackTrans_o = 1'b1;
            end
        end
    end

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            ep0State_o <= IDLE;
            requestError <= 1'b0;
            dataToggle <= 1'b0;
            pendingAddr <= 1'b0;
        end else begin
            ep0State_o <= nextState;
            requestError <= nextError;
            dataToggle <= nextToggle;
            pendingAddr <= nextPendingAddr;
        end
    end

endmodule

`default_nettype wire

/* setupCapture.sv */
`timescale 1ns/1ps
`default_nettype none

module setupCapture (
    input  logic   clk48_i,
    input  logic   rstN_i,
    input  logic   transStart_i,
    input  logic   byteValid_i,
    input  logic   [7:0] byte_i,
    input  logic   accept_i,
    output logic   full_o,
    ep0ReqIf.capture req
);
    import ep0Pkg::*;

    logic [SetupBytes*8-1:0] setupReg;
    // One bit per captured byte, top bit means full
    logic [SetupBytes-1:0] fillMask;
    // Low while the PID byte is still expected
    logic byteIsData;
    logic byteTaken;

    // Only open while the FSM waits for a new request
    assign full_o = fillMask[SetupBytes-1] || !accept_i;
    assign byteTaken = byteValid_i && !full_o;

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            setupReg <= '0;
            fillMask <= '0;
            byteIsData <= 1'b0;
        end else if (transStart_i) begin
            // New token empties the buffer, old fields stay readable
            fillMask <= '0;
            byteIsData <= 1'b0;
        end else if (byteTaken) begin
            if (!byteIsData) begin
                // PID byte skipped
                byteIsData <= 1'b1;
            end else begin
                // Bytes arrive LSB first, shift in from the top
                setupReg <= {byte_i, setupReg[SetupBytes*8-1:8]};
                fillMask <= {fillMask[SetupBytes-2:0], 1'b1};
            end
        end
    end

    // Field layout after all eight bytes
    assign req.devToHost = setupReg[7];
    assign req.bRequest = setupReg[15:8];
    assign req.wValue = setupReg[31:16];
    assign req.wIndex = setupReg[47:32];
    assign req.wLength = setupReg[63:48];

endmodule

`default_nettype wire

/* tbEndpoint0.sv */
`timescale 1ns/1ps
`default_nettype none

module tbEndpoint0;
    import ep0Pkg::*;

    localparam int NumRows = 8;
    localparam int ResetCycles = 10;
    localparam int CycleLimit = 80 * NumRows + ResetCycles;
    // DATA PIDs as bits 3:2
    localparam logic [1:0] Data0 = 2'b00;
    localparam logic [1:0] Data1 = 2'b10;

    // Setup bytes read left to right, bmRequestType first
    typedef struct packed {
        logic usbReset;
        logic [63:0] setup;
        logic failOnce;
        logic [1:0] statusToken;
        logic [DevAddrWidth-1:0] expAddr;
        logic [DevConfWidth-1:0] expConf;
        logic [1:0] expPid;
        logic [15:0] expCount;
    } TestRow;

    logic clk48_i;
    logic rstN_i;
    logic usbResetDetected_i;
    logic gotTransStartPacket_i;
    logic [1:0] transStartTokenId_i;
    logic epInFillTransDone_i;
    logic epInFillTransSuccess_i;
    logic epInDataValid_i;
    logic [7:0] epInData_i;
    logic epInFull_o;
    logic epOutPopTransDone_i;
    logic epOutPopTransSuccess_i;
    logic epOutPopData_i;
    logic epOutDataAvailable_o;
    logic epOutIsLastPacketByte_o;
    logic [7:0] epOutData_o;
    logic ackUsbResetDetect_o;
    logic [DevAddrWidth-1:0] deviceAddr_o;
    logic [DevConfWidth-1:0] deviceConf_o;
    logic respHandshakePid_o;
    logic [1:0] respPacketId_o;

    TestRow rows [NumRows];
    int errors = 0;
    int cycles = 0;

    usbEndpoint0 dut (.*);

    // ====================
    // Clock and timeout
    // ====================

    initial begin
        clk48_i = 1'b0;
        forever #5 clk48_i = ~clk48_i;
    end

    always @(posedge clk48_i) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("Timeout: no progress within %0d cycles", CycleLimit);
            $display("test failed");
            $finish;
        end
    end

    // ====================
    // Helpers
    // ====================

    // Inputs change 1 ns after the edge, outputs are read at the falling edge
    task automatic driveEdge();
        @(posedge clk48_i);
        #1;
    endtask

    task automatic reportMismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
        $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        errors++;
    endtask

    // Descriptor bytes by type, or the configuration value
    function automatic logic [7:0] expectedByte(input TestRow row, input int i);
        int base;
        if (row.setup[55:48] == GET_CONFIGURATION) begin
            return row.expConf;
        end
        base = (row.setup[39:32] == DESC_CONFIGURATION) ? ConfDescStart : 0;
        return DescRomBytes[base + i];
    endfunction

    // Handshake for host to device requests and for stalls
    function automatic logic expectHandshake(input TestRow row);
        return !row.setup[63] || row.expPid == RES_STALL;
    endfunction

    task automatic setupTransaction(input logic [63:0] setup);
        logic [7:0] pkt [9];
        int idx;
        // SETUP data packet starts with its DATA0 PID byte
        pkt[0] = 8'hC3;
        for (int k = 0; k < SetupBytes; k++) begin
            pkt[k + 1] = setup[63 - 8 * k -: 8];
        end
        gotTransStartPacket_i = 1'b1;
        transStartTokenId_i = TOKEN_SETUP;
        driveEdge();
        gotTransStartPacket_i = 1'b0;
        idx = 0;
        while (idx < 9) begin
            epInDataValid_i = 1'b1;
            epInData_i = pkt[idx];
            @(negedge clk48_i);
            // Byte moves at the next edge only if not full
            if (!epInFull_o) begin
                idx++;
            end
            driveEdge();
        end
        epInDataValid_i = 1'b0;
        epInFillTransDone_i = 1'b1;
        epInFillTransSuccess_i = 1'b1;
        @(negedge clk48_i);
        // Eighth data byte closes the buffer while still in NEW_REQUEST
        if (epInFull_o !== 1'b1) begin
            reportMismatch("epInFull_o", epInFull_o, 1'b1);
        end
        driveEdge();
        epInFillTransDone_i = 1'b0;
        epInFillTransSuccess_i = 1'b0;
    endtask

    task automatic inStage(input TestRow row, input int nPop, input logic success);
        int i;
        gotTransStartPacket_i = 1'b1;
        transStartTokenId_i = TOKEN_IN;
        driveEdge();
        gotTransStartPacket_i = 1'b0;
        i = 0;
        while (i < nPop) begin
            epOutPopData_i = 1'b1;
            @(negedge clk48_i);
            if (epOutDataAvailable_o) begin
                if (epOutData_o !== expectedByte(row, i)) begin
                    reportMismatch("epOutData_o", epOutData_o, expectedByte(row, i));
                end
                if (epOutIsLastPacketByte_o !== (i == row.expCount - 1)) begin
                    reportMismatch("epOutIsLastPacketByte_o", epOutIsLastPacketByte_o,
                                   i == row.expCount - 1);
                end
                if (respPacketId_o !== row.expPid) begin
                    reportMismatch("respPacketId_o", respPacketId_o, row.expPid);
                end
                if (respHandshakePid_o !== expectHandshake(row)) begin
                    reportMismatch("respHandshakePid_o", respHandshakePid_o,
                                   expectHandshake(row));
                end
                i++;
            end
            driveEdge();
        end
        epOutPopData_i = 1'b0;
        epOutPopTransDone_i = 1'b1;
        epOutPopTransSuccess_i = success;
        driveEdge();
        epOutPopTransDone_i = 1'b0;
        epOutPopTransSuccess_i = 1'b0;
    endtask

    // Response is read in the token cycle, before the start pulse clears the error
    task automatic statusCheck(input TestRow row);
        gotTransStartPacket_i = 1'b1;
        transStartTokenId_i = row.statusToken;
        @(negedge clk48_i);
        if (respPacketId_o !== row.expPid) begin
            reportMismatch("respPacketId_o", respPacketId_o, row.expPid);
        end
        if (respHandshakePid_o !== expectHandshake(row)) begin
            reportMismatch("respHandshakePid_o", respHandshakePid_o, expectHandshake(row));
        end
        driveEdge();
        gotTransStartPacket_i = 1'b0;
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        int startErrors;
        int passedRows;
        logic [DevAddrWidth-1:0] prevAddr;
        rstN_i = 1'b0;
        usbResetDetected_i = 1'b0;
        gotTransStartPacket_i = 1'b0;
        transStartTokenId_i = TOKEN_OUT;
        epInFillTransDone_i = 1'b0;
        epInFillTransSuccess_i = 1'b0;
        epInDataValid_i = 1'b0;
        epInData_i = 8'h00;
        epOutPopTransDone_i = 1'b0;
        epOutPopTransSuccess_i = 1'b0;
        epOutPopData_i = 1'b0;
        passedRows = 0;
        prevAddr = '0;

        // USB reset, setup, fail once, status token, addr, conf, PID, byte count
        rows[0] = '{1'b1, 64'h8006_0001_0000_1200, 1'b1, TOKEN_OUT, 7'd0, 8'd0, Data1, 16'd18};
        rows[1] = '{1'b0, 64'h8006_0002_0000_0900, 1'b0, TOKEN_OUT, 7'd0, 8'd0, Data1, 16'd9};
        rows[2] = '{1'b0, 64'h0005_0500_0000_0000, 1'b0, TOKEN_IN, 7'd5, 8'd0, Data1, 16'd0};
        rows[3] = '{1'b0, 64'h0009_0100_0000_0000, 1'b0, TOKEN_IN, 7'd5, 8'd1, Data1, 16'd0};
        rows[4] = '{1'b0, 64'h8008_0000_0000_0100, 1'b0, TOKEN_OUT, 7'd5, 8'd1, Data1, 16'd1};
        rows[5] = '{1'b0, 64'h8000_0000_0000_0200, 1'b0, TOKEN_OUT, 7'd5, 8'd1, RES_STALL, 16'd0};
        rows[6] = '{1'b0, 64'h8006_0102_0000_0900, 1'b0, TOKEN_OUT, 7'd5, 8'd1, RES_STALL, 16'd0};
        rows[7] = '{1'b1, 64'h8008_0000_0000_0100, 1'b0, TOKEN_OUT, 7'd0, 8'd0, RES_STALL, 16'd0};

        repeat (ResetCycles) @(posedge clk48_i);
        #1;
        rstN_i = 1'b1;
        @(negedge clk48_i);
        // Idle endpoint after reset
        if (epInFull_o !== 1'b1) reportMismatch("epInFull_o", epInFull_o, 1'b1);
        if (epOutDataAvailable_o !== 1'b0) begin
            reportMismatch("epOutDataAvailable_o", epOutDataAvailable_o, 1'b0);
        end
        if (ackUsbResetDetect_o !== 1'b0) begin
            reportMismatch("ackUsbResetDetect_o", ackUsbResetDetect_o, 1'b0);
        end
        if (deviceAddr_o !== '0) reportMismatch("deviceAddr_o", deviceAddr_o, 0);
        if (deviceConf_o !== '0) reportMismatch("deviceConf_o", deviceConf_o, 0);
        driveEdge();

        for (int r = 0; r < NumRows; r++) begin
            startErrors = errors;
            if (rows[r].usbReset) begin
                usbResetDetected_i = 1'b1;
                driveEdge();
                usbResetDetected_i = 1'b0;
                @(negedge clk48_i);
                if (ackUsbResetDetect_o !== 1'b1) begin
                    reportMismatch("ackUsbResetDetect_o", ackUsbResetDetect_o, 1'b1);
                end
                if (deviceAddr_o !== '0) reportMismatch("deviceAddr_o", deviceAddr_o, 0);
                if (deviceConf_o !== '0) reportMismatch("deviceConf_o", deviceConf_o, 0);
                driveEdge();
                prevAddr = '0;
            end
            setupTransaction(rows[r].setup);
            // New address waits for the status stage
            @(negedge clk48_i);
            if (deviceAddr_o !== prevAddr) reportMismatch("deviceAddr_o", deviceAddr_o, prevAddr);
            driveEdge();
            if (rows[r].expCount != 0) begin
                if (rows[r].failOnce) begin
                    inStage(rows[r], 3, 1'b0);
                end
                inStage(rows[r], rows[r].expCount, 1'b1);
                // Next IN token sees the other DATA PID
                gotTransStartPacket_i = 1'b1;
                transStartTokenId_i = TOKEN_IN;
                @(negedge clk48_i);
                if (epOutDataAvailable_o !== 1'b0) begin
                    reportMismatch("epOutDataAvailable_o", epOutDataAvailable_o, 1'b0);
                end
                if (respPacketId_o !== (rows[r].expPid == Data1 ? Data0 : Data1)) begin
                    reportMismatch("respPacketId_o", respPacketId_o,
                                   rows[r].expPid == Data1 ? Data0 : Data1);
                end
                driveEdge();
                gotTransStartPacket_i = 1'b0;
            end else begin
                statusCheck(rows[r]);
            end
            @(negedge clk48_i);
            if (deviceAddr_o !== rows[r].expAddr) begin
                reportMismatch("deviceAddr_o", deviceAddr_o, rows[r].expAddr);
            end
            if (deviceConf_o !== rows[r].expConf) begin
                reportMismatch("deviceConf_o", deviceConf_o, rows[r].expConf);
            end
            driveEdge();
            prevAddr = rows[r].expAddr;
            if (errors == startErrors) begin
                passedRows++;
                $display("row %0d bRequest 0x%0h: ok", r, rows[r].setup[55:48]);
            end else begin
                $display("row %0d bRequest 0x%0h: %0d errors", r, rows[r].setup[55:48],
                         errors - startErrors);
            end
        end

        $display("%0d rows passed, %0d rows failed, %0d errors", passedRows,
                 NumRows - passedRows, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* usbEndpoint0.sv */
`timescale 1ns/1ps
`default_nettype none

module usbEndpoint0 (
    input  logic clk48_i,
    input  logic rstN_i,
    input  logic usbResetDetected_i,
    input  logic gotTransStartPacket_i,
    input  logic [1:0] transStartTokenId_i,
    // IN side, setup bytes from the host
    input  logic epInFillTransDone_i,
    input  logic epInFillTransSuccess_i,
    input  logic epInDataValid_i,
    input  logic [7:0] epInData_i,
    output logic epInFull_o,
    // OUT side, data stage bytes to the host
    input  logic epOutPopTransDone_i,
    input  logic epOutPopTransSuccess_i,
    input  logic epOutPopData_i,
    output logic epOutDataAvailable_o,
    output logic epOutIsLastPacketByte_o,
    output logic [7:0] epOutData_o,
    output logic ackUsbResetDetect_o,
    output logic [ep0Pkg::DevAddrWidth-1:0] deviceAddr_o,
    output logic [ep0Pkg::DevConfWidth-1:0] deviceConf_o,
    output logic respHandshakePid_o,
    output logic [1:0] respPacketId_o
);
    import ep0Pkg::*;

    ep0ReqIf reqIf ();

    Ep0State ep0State;
    DeviceState devState;
    logic acceptSetup;
    logic addrCommit;
    logic confCommit;
    logic loadCount;
    logic [RomIdxWidth-1:0] romStart;
    logic popByte;
    logic commitTrans;
    logic rollbackTrans;
    logic [RomIdxWidth-1:0] romIdx;
    logic [15:0] bytesLeft;
    logic [7:0] romData;

    assign acceptSetup = ep0State == NEW_REQUEST;

    // ====================
    // Blocks
    // ====================

    setupCapture uCapture (
        .clk48_i(clk48_i),
        .rstN_i(rstN_i),
        .transStart_i(gotTransStartPacket_i),
        .byteValid_i(epInDataValid_i),
        .byte_i(epInData_i),
        .accept_i(acceptSetup),
        .full_o(epInFull_o),
        .req(reqIf.capture)
    );

    descRom uRom (
        .idx_i(romIdx),
        .data_o(romData)
    );

    ep0ByteCounter uCounter (
        .clk48_i(clk48_i),
        .rstN_i(rstN_i),
        .loadCount_i(loadCount),
        .romStart_i(romStart),
        .popByte_i(popByte),
        .commitTrans_i(commitTrans),
        .rollbackTrans_i(rollbackTrans),
        .req(reqIf.user),
        .romIdx_o(romIdx),
        .bytesLeft_o(bytesLeft)
    );

    deviceStateTracker uDevState (
        .clk48_i(clk48_i),
        .rstN_i(rstN_i),
        .usbReset_i(usbResetDetected_i),
        .addrCommit_i(addrCommit),
        .confCommit_i(confCommit),
        .req(reqIf.user),
        .devState_o(devState),
        .deviceAddr_o(deviceAddr_o),
        .deviceConf_o(deviceConf_o),
        .ackUsbReset_o(ackUsbResetDetect_o)
    );

    ep0RequestFsm uFsm (
        .clk48_i(clk48_i),
        .rstN_i(rstN_i),
        .transStart_i(gotTransStartPacket_i),
        .tokenId_i(TokenId'(transStartTokenId_i)),
        .fillDone_i(epInFillTransDone_i),
        .fillSuccess_i(epInFillTransSuccess_i),
        .popData_i(epOutPopData_i),
        .popDone_i(epOutPopTransDone_i),
        .popSuccess_i(epOutPopTransSuccess_i),
        .bytesLeft_i(bytesLeft),
        .devState_i(devState),
        .req(reqIf.user),
        .ep0State_o(ep0State),
        .dataAvailable_o(epOutDataAvailable_o),
        .lastByte_o(epOutIsLastPacketByte_o),
        .addrCommit_o(addrCommit),
        .confCommit_o(confCommit),
        .loadCount_o(loadCount),
        .romStart_o(romStart),
        .popByte_o(popByte),
        .commitTrans_o(commitTrans),
        .rollbackTrans_o(rollbackTrans),
        .respHandshakePid_o(respHandshakePid_o),
        .respPacketId_o(respPacketId_o)
    );

    // Descriptor bytes or the current configuration value
    always_comb begin
        case (ep0State)
            SEND_DESC: epOutData_o = romData;
            SEND_VAL: epOutData_o = deviceConf_o;
            default: epOutData_o = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

/* vlog.f */
ep0Pkg.sv
ep0ReqIf.sv
setupCapture.sv
descRom.sv
ep0ByteCounter.sv
deviceStateTracker.sv
ep0RequestFsm.sv
usbEndpoint0.sv
tbEndpoint0.sv
